/* files.f */
+incdir+design
design/rvIsaPkg.sv
design/cpuCtrlPkg.sv
design/fetchStage.sv
design/runControl.sv
design/decoder.sv
design/regFile.sv
design/alu.sv
design/dataMem.sv
design/cpu.sv
verification/cpu_sva.sv
verification/cpuTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module cpuTb -o simCpu

out=$(./obj_dir/simCpu)
echo "$out"

echo "$out" | grep -q '\*\*\* PASSED \*\*\*'

/* verification/cpuTb.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpuTb;

  localparam int NumTests      = 5;
  localparam int CyclesPerTest = 400;
  localparam int PeriodNs      = 4;
  localparam int WatchdogNs    = NumTests * CyclesPerTest * PeriodNs;
  localparam logic [31:0] Ebreak = 32'h0010_0073;

  logic                  clk;
  logic                  rst;
  logic                  start;
  logic                  imemWe;
  logic [`ImemAddrW-1:0] imemAddr;
  logic [`XLEN-1:0]      imemData;
  logic [`RegIdxW-1:0]   dbgAddr;
  logic [`XLEN-1:0]      dbgData;
  logic                  done;
  logic                  trap;
  logic [`XLEN-1:0]      pc;

  logic [31:0] prog [$];
  int          errCount;
  int          testErrStart;
  int          passCount;
  int          failCount;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] w;
  logic [31:0] savedPc;
  int          jalPc;
  int          auiPc;

  // branch funct3 with operand indices for the taken and not-taken cases
  logic [2:0] brF3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  logic [4:0] tkA  [6] = '{5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
  logic [4:0] tkB  [6] = '{5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
  logic [4:0] ntA  [6] = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
  logic [4:0] ntB  [6] = '{5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};

  cpu u_cpu (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .imemWe   (imemWe),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .dbgAddr  (dbgAddr),
    .dbgData  (dbgData),
    .done     (done),
    .trap     (trap),
    .pc       (pc)
  );

  bind cpu cpuSva uCpuSva (
    .clk     (clk),
    .rst     (rst),
    .done    (done),
    .trap    (trap),
    .pc      (pc),
    .dbgAddr (dbgAddr),
    .dbgData (dbgData)
  );

  always #(PeriodNs / 2) clk = ~clk;

  // instruction encoders
  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return encI(imm, rs1, 3'b000, rd, 7'h13);
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // lui then addi with the upper part rounded for the sign of the low 12 bits
  task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    emit(encU(hi[31:12], rd, 7'h37));
    emit(addi(rd, rd, value[11:0]));
  endtask

  task automatic writeImem;
    for (int i = 0; i < prog.size(); i++) begin
      @(negedge clk);
      imemWe   = 1'b1;
      imemAddr = 8'(i);
      imemData = prog[i];
    end
    @(negedge clk);
    imemWe = 1'b0;
    prog.delete();
  endtask

  // a stopped core needs one start to go idle and a second to run
  task automatic runProgram;
    int cycles;
    cycles = 0;
    if (done || trap) begin
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      @(negedge clk);
    end
    // reset and restart both leave the fetch pc at the reset vector
    checkEq("pc", pc, `PcReset);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!(done || trap) && cycles < CyclesPerTest) begin
      @(negedge clk);
      cycles++;
    end
    if (!(done || trap)) begin
      $display("%0t: program did not halt or trap within %0d cycles", $time, cycles);
      errCount++;
    end
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkTrue(input bit cond, input string what);
    assert (cond) else begin
      $display("%0t: %s", $time, what);
      errCount++;
    end
  endtask

  task automatic checkReg(input logic [4:0] idx, input logic [31:0] exp);
    @(negedge clk);
    dbgAddr = idx;
    #1;
    checkEq($sformatf("x%0d", idx), dbgData, exp);
  endtask

  task automatic finishTest(input string name);
    if (errCount == testErrStart) begin
      $display("test %s: ok", name);
      passCount++;
    end else begin
      $display("test %s: failed with %0d errors", name, errCount - testErrStart);
      failCount++;
    end
    testErrStart = errCount;
    @(negedge clk);
  endtask

  initial begin
    #(WatchdogNs);
    $display("watchdog expired after %0d ns, the run is stuck", WatchdogNs);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    start    = 1'b0;
    imemWe   = 1'b0;
    imemAddr = '0;
    imemData = '0;
    dbgAddr  = '0;
    errCount     = 0;
    testErrStart = 0;
    passCount    = 0;
    failCount    = 0;
    void'($urandom(32'ha06480d6));
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // register-register ALU ops on random operands
    a = $urandom;
    b = $urandom;
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    emit(encR(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
    emit(encR(7'h20, 3'd0, 5'd4, 5'd1, 5'd2));
    emit(encR(7'h00, 3'd1, 5'd5, 5'd1, 5'd2));
    emit(encR(7'h00, 3'd5, 5'd6, 5'd1, 5'd2));
    emit(encR(7'h20, 3'd5, 5'd7, 5'd1, 5'd2));
    emit(encR(7'h00, 3'd2, 5'd8, 5'd1, 5'd2));
    emit(encR(7'h00, 3'd3, 5'd9, 5'd1, 5'd2));
    emit(encR(7'h00, 3'd4, 5'd10, 5'd1, 5'd2));
    emit(encR(7'h00, 3'd6, 5'd11, 5'd1, 5'd2));
    emit(encR(7'h00, 3'd7, 5'd12, 5'd1, 5'd2));
    emit(addi(5'd0, 5'd1, 12'd0));
    emit(Ebreak);
    writeImem();
    runProgram();
    checkReg(5'd1, a);
    checkReg(5'd2, b);
    checkReg(5'd3, a + b);
    checkReg(5'd4, a - b);
    checkReg(5'd5, a << b[4:0]);
    checkReg(5'd6, a >> b[4:0]);
    checkReg(5'd7, $signed(a) >>> b[4:0]);
    checkReg(5'd8, {31'b0, $signed(a) < $signed(b)});
    checkReg(5'd9, {31'b0, a < b});
    checkReg(5'd10, a ^ b);
    checkReg(5'd11, a | b);
    checkReg(5'd12, a & b);
    checkReg(5'd0, 32'h0);
    finishTest("alu");

    // sign bits forced so the signed loads extend ones
    w = $urandom | 32'h8000_8000;
    emit(addi(5'd1, 5'd0, 12'h100));
    loadConst(5'd2, w);
    emit(encS(12'd0, 5'd1, 5'd2, 3'd2));
    emit(encS(12'd6, 5'd1, 5'd2, 3'd1));
    emit(encS(12'd8, 5'd1, 5'd0, 3'd2));
    emit(encS(12'd9, 5'd1, 5'd2, 3'd0));
    emit(encI(12'd3, 5'd1, 3'd0, 5'd3, 7'h03));
    emit(encI(12'd3, 5'd1, 3'd4, 5'd4, 7'h03));
    emit(encI(12'd2, 5'd1, 3'd1, 5'd5, 7'h03));
    emit(encI(12'd6, 5'd1, 3'd5, 5'd6, 7'h03));
    emit(encI(12'd0, 5'd1, 3'd2, 5'd7, 7'h03));
    emit(encI(12'd9, 5'd1, 3'd4, 5'd8, 7'h03));
    emit(encI(12'd8, 5'd1, 3'd2, 5'd9, 7'h03));
    emit(Ebreak);
    writeImem();
    runProgram();
    checkReg(5'd3, {{24{w[31]}}, w[31:24]});
    checkReg(5'd4, {24'b0, w[31:24]});
    checkReg(5'd5, {{16{w[31]}}, w[31:16]});
    checkReg(5'd6, {16'b0, w[15:0]});
    checkReg(5'd7, w);
    checkReg(5'd8, {24'b0, w[7:0]});
    checkReg(5'd9, {16'b0, w[7:0], 8'b0});
    finishTest("load_store");

    // taken branches skip a poison write, not-taken ones set a marker
    loadConst(5'd1, 32'd5);
    loadConst(5'd2, 32'hFFFF_FFFD);
    for (int r = 3; r <= 8; r++) begin
      emit(addi(5'(r), 5'd0, 12'd0));
    end
    emit(addi(5'd16, 5'd0, 12'd0));
    emit(addi(5'd19, 5'd0, 12'd0));
    for (int k = 0; k < 6; k++) begin
      emit(encB(13'd8, tkA[k], tkB[k], brF3[k]));
      emit(addi(5'(3 + k), 5'd0, 12'd99));
      emit(encB(13'd8, ntA[k], ntB[k], brF3[k]));
      emit(addi(5'(9 + k), 5'd0, 12'(10 + k)));
    end
    jalPc = prog.size() * 4;
    emit(encJ(21'd8, 5'd15));
    emit(addi(5'd16, 5'd0, 12'd99));
    auiPc = prog.size() * 4;
    emit(encU(20'd0, 5'd17, 7'h17));
    // odd offset whose target drops bit 0
    emit(encI(12'd13, 5'd17, 3'd0, 5'd18, 7'h67));
    emit(addi(5'd19, 5'd0, 12'd99));
    // auipc at the jalr target sees the even pc
    emit(encU(20'd0, 5'd26, 7'h17));
    emit(Ebreak);
    writeImem();
    runProgram();
    for (int k = 0; k < 6; k++) begin
      checkReg(5'(3 + k), 32'h0);
      checkReg(5'(9 + k), 32'(10 + k));
    end
    checkReg(5'd15, 32'(jalPc + 4));
    checkReg(5'd16, 32'h0);
    checkReg(5'd17, 32'(auiPc));
    checkReg(5'd18, 32'(auiPc + 8));
    checkReg(5'd19, 32'h0);
    checkReg(5'd26, 32'(auiPc + 12));
    finishTest("control_flow");

    emit(addi(5'd21, 5'd0, 12'd0));
    emit(addi(5'd20, 5'd0, 12'd77));
    emit(Ebreak);
    emit(addi(5'd20, 5'd0, 12'd55));
    emit(addi(5'd21, 5'd0, 12'd1));
    writeImem();
    runProgram();
    checkTrue(done == 1'b1, "done did not rise after ebreak");
    checkTrue(trap == 1'b0, "trap rose after ebreak");
    savedPc = pc;
    repeat (10) @(negedge clk);
    checkEq("pc", pc, savedPc);
    checkTrue(done == 1'b1, "done dropped while halted");
    checkReg(5'd20, 32'd77);
    checkReg(5'd21, 32'h0);
    finishTest("ebreak");

    // mul is outside RV32I
    emit(addi(5'd22, 5'd0, 12'd0));
    emit(addi(5'd24, 5'd0, 12'd0));
    emit(addi(5'd23, 5'd0, 12'd5));
    emit(encR(7'h01, 3'd0, 5'd22, 5'd23, 5'd23));
    emit(addi(5'd24, 5'd0, 12'd9));
    emit(Ebreak);
    writeImem();
    runProgram();
    checkTrue(trap == 1'b1, "trap did not rise on an illegal instruction");
    checkTrue(done == 1'b0, "done rose on an illegal instruction");
    checkReg(5'd22, 32'h0);
    checkReg(5'd23, 32'd5);
    checkReg(5'd24, 32'h0);
    @(negedge clk);
    emit(addi(5'd25, 5'd0, 12'd123));
    emit(Ebreak);
    writeImem();
    runProgram();
    checkTrue(done == 1'b1, "restarted program did not halt");
    checkTrue(trap == 1'b0, "restarted program trapped");
    checkReg(5'd25, 32'd123);
    finishTest("illegal");

    $display("tests passed: %0d, failed: %0d, errors: %0d", passCount, failCount, errCount);
    if (failCount == 0 && errCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verification/cpu_sva.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpuSva (
  input logic                clk,
  input logic                rst,
  input logic                done,
  input logic                trap,
  input logic [`XLEN-1:0]    pc,
  input logic [`RegIdxW-1:0] dbgAddr,
  input logic [`XLEN-1:0]    dbgData
);

  // status outputs come out of reset low
  statusLowAfterReset: assert property (
    @(posedge clk) rst |=> (!done && !trap)
  ) else $error("done or trap high right after reset");

  // halted and trapped are separate states
  doneTrapExclusive: assert property (
    @(posedge clk) disable iff (rst) !(done && trap)
  ) else $error("done and trap high in the same cycle");

  // a stopped core must not fetch
  pcFrozenWhenStopped: assert property (
    @(posedge clk) disable iff (rst) (done || trap) |-> $stable(pc)
  ) else $error("pc moved while the core was halted or trapped");

  // x0 is hardwired
  zeroRegReadsZero: assert property (
    @(posedge clk) disable iff (rst) (dbgAddr == '0) |-> (dbgData == '0)
  ) else $error("x0 read back a nonzero value");

endmodule

/* design/cpu.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  imemWe,
  input  logic [`ImemAddrW-1:0] imemAddr,
  input  logic [`XLEN-1:0]      imemData,
  input  logic [`RegIdxW-1:0]   dbgAddr,
  output logic [`XLEN-1:0]      dbgData,
  output logic                  done,
  output logic                  trap,
  output logic [`XLEN-1:0]      pc
);

  logic                runEn;
  logic                restart;
  logic                haltReq;
  logic                illegalReq;
  logic [`XLEN-1:0]    pcId;
  logic [`XLEN-1:0]    instId;
  logic [`RegIdxW-1:0] rs1;
  logic [`RegIdxW-1:0] rs2;
  logic [`RegIdxW-1:0] rd;
  logic [`XLEN-1:0]    imm;
  rvIsaPkg::aluOpT     aluOp;
  rvIsaPkg::memWidthT  memWidth;
  logic                regWe;
  logic                memWe;
  logic                memRe;
  logic                isUnsigned;
  logic                useImm;
  logic                usePc;
  logic                isJump;
  logic                isBranch;
  logic                isEbreak;
  logic                illegal;
  logic [`XLEN-1:0]    rdata1;
  logic [`XLEN-1:0]    rdata2;
  logic [`XLEN-1:0]    opA;
  logic [`XLEN-1:0]    opB;
  logic [`XLEN-1:0]    aluResult;
  logic [`XLEN-1:0]    loadData;
  logic [`XLEN-1:0]    wbData;
  logic                branchTaken;
  logic                flush;
  cpuCtrlPkg::pcSrcT   pcSrc;
  logic [`XLEN-1:0]    targetPc;

  runControl uRunControl (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .haltReq    (haltReq),
    .illegalReq (illegalReq),
    .runEn      (runEn),
    .restart    (restart),
    .done       (done),
    .trap       (trap)
  );

  fetchStage uFetchStage (
    .clk      (clk),
    .rst      (rst),
    .runEn    (runEn),
    .restart  (restart),
    .pcSrc    (pcSrc),
    .targetPc (targetPc),
    .flush    (flush),
    .imemWe   (imemWe),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .pc       (pc),
    .pcId     (pcId),
    .instId   (instId)
  );

  decoder uDecoder (
    .instId     (instId),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .aluOp      (aluOp),
    .memWidth   (memWidth),
    .regWe      (regWe),
    .memWe      (memWe),
    .memRe      (memRe),
    .isUnsigned (isUnsigned),
    .useImm     (useImm),
    .usePc      (usePc),
    .isJump     (isJump),
    .isBranch   (isBranch),
    .isEbreak   (isEbreak),
    .illegal    (illegal)
  );

  // write strobes only count while running
  regFile uRegFile (
    .clk     (clk),
    .we      (regWe && runEn),
    .rd      (rd),
    .wdata   (wbData),
    .rs1     (rs1),
    .rs2     (rs2),
    .dbgAddr (dbgAddr),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .dbgData (dbgData)
  );

  // pc is operand a for auipc and jal
  assign opA = usePc ? pcId : rdata1;
  assign opB = useImm ? imm : rdata2;

  alu uAlu (
    .opA    (opA),
    .opB    (opB),
    .aluOp  (aluOp),
    .result (aluResult)
  );

  dataMem uDataMem (
    .clk        (clk),
    .we         (memWe && runEn),
    .re         (memRe),
    .addr       (aluResult),
    .wdata      (rdata2),
    .memWidth   (memWidth),
    .isUnsigned (isUnsigned),
    .rdata      (loadData)
  );

  always_comb begin
    if (isJump) wbData = pcId + `XLEN'(4);
    else if (memRe) wbData = loadData;
    else wbData = aluResult;
  end

  assign haltReq    = isEbreak && runEn;
  assign illegalReq = illegal && runEn;

  // compare result bit 0 decides the branch
  assign branchTaken = isBranch && aluResult[0];
  assign flush       = runEn && (isJump || branchTaken);

  always_comb begin
    if (isJump) pcSrc = cpuCtrlPkg::pcJump;
    else if (branchTaken) pcSrc = cpuCtrlPkg::pcBranch;
    else pcSrc = cpuCtrlPkg::pcSeq;
  end

  // jalr needs bit 0 cleared, jal targets are already even
  assign targetPc = isJump ? {aluResult[`XLEN-1:1], 1'b0} : pcId + imm;

endmodule

/* design/dataMem.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module dataMem (
  input  logic                clk,
  input  logic                we,
  input  logic                re,
  input  logic [`XLEN-1:0]    addr,
  input  logic [`XLEN-1:0]    wdata,
  input  rvIsaPkg::memWidthT  memWidth,
  input  logic                isUnsigned,
  output logic [`XLEN-1:0]    rdata
);

  logic [7:0]            mem [`DmemBytes];
  logic [`DmemAddrW-1:0] base;
  logic [`DmemAddrW-1:0] lane1;
  logic [`DmemAddrW-1:0] lane2;
  logic [`DmemAddrW-1:0] lane3;
  logic [`XLEN-1:0]      loadExt;

  // misaligned addresses drop their low bits
  always_comb begin
    case (memWidth)
      rvIsaPkg::memByte: base = addr[`DmemAddrW-1:0];
      rvIsaPkg::memHalf: base = {addr[`DmemAddrW-1:1], 1'b0};
      default:           base = {addr[`DmemAddrW-1:2], 2'b00};
    endcase
  end

  assign lane1 = {base[`DmemAddrW-1:1], 1'b1};
  assign lane2 = {base[`DmemAddrW-1:2], 2'b10};
  assign lane3 = {base[`DmemAddrW-1:2], 2'b11};

  always_ff @(posedge clk) begin
    if (we) begin
      mem[base] <= wdata[7:0];
      if (memWidth != rvIsaPkg::memByte) begin
        mem[lane1] <= wdata[15:8];
      end
      if (memWidth == rvIsaPkg::memWord) begin
        mem[lane2] <= wdata[23:16];
        mem[lane3] <= wdata[31:24];
      end
    end
  end

  always_comb begin
    case (memWidth)
      rvIsaPkg::memByte:
        loadExt = {{(`XLEN-8){~isUnsigned & mem[base][7]}}, mem[base]};
      rvIsaPkg::memHalf:
        loadExt = {{(`XLEN-16){~isUnsigned & mem[lane1][7]}}, mem[lane1], mem[base]};
      default:
        loadExt = {mem[lane3], mem[lane2], mem[lane1], mem[base]};
    endcase
  end

  assign rdata = re ? loadExt : '0;

endmodule

/* design/alu.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module alu (
  input  logic [`XLEN-1:0] opA,
  input  logic [`XLEN-1:0] opB,
  input  rvIsaPkg::aluOpT  aluOp,
  output logic [`XLEN-1:0] result
);

  logic [$clog2(`XLEN)-1:0] shamt;
  logic                     flag;

  assign shamt = opB[$clog2(`XLEN)-1:0];

  // single-bit outcome of the compare ops
  always_comb begin
    case (aluOp)
      rvIsaPkg::aluSlt:  flag = $signed(opA) < $signed(opB);
      rvIsaPkg::aluSltu: flag = opA < opB;
      rvIsaPkg::aluEq:   flag = opA == opB;
      rvIsaPkg::aluNe:   flag = opA != opB;
      rvIsaPkg::aluGe:   flag = $signed(opA) >= $signed(opB);
      rvIsaPkg::aluGeu:  flag = opA >= opB;
      default:           flag = 1'b0;
    endcase
  end

  always_comb begin
    case (aluOp)
      rvIsaPkg::aluAdd:   result = opA + opB;
      rvIsaPkg::aluSub:   result = opA - opB;
      rvIsaPkg::aluSll:   result = opA << shamt;
      rvIsaPkg::aluXor:   result = opA ^ opB;
      rvIsaPkg::aluSrl:   result = opA >> shamt;
      rvIsaPkg::aluSra:   result = $signed(opA) >>> shamt;
      rvIsaPkg::aluOr:    result = opA | opB;
      rvIsaPkg::aluAnd:   result = opA & opB;
      rvIsaPkg::aluPassB: result = opB;
      default:            result = {{(`XLEN-1){1'b0}}, flag};
    endcase
  end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module regFile (
  input  logic                clk,
  input  logic                we,
  input  logic [`RegIdxW-1:0] rd,
  input  logic [`XLEN-1:0]    wdata,
  input  logic [`RegIdxW-1:0] rs1,
  input  logic [`RegIdxW-1:0] rs2,
  input  logic [`RegIdxW-1:0] dbgAddr,
  output logic [`XLEN-1:0]    rdata1,
  output logic [`XLEN-1:0]    rdata2,
  output logic [`XLEN-1:0]    dbgData
);

  logic [`XLEN-1:0] regs [`RegCount];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 is never stored, so force zero on every read port
  assign rdata1  = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2  = (rs2 == '0) ? '0 : regs[rs2];
  assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

/* design/decoder.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module decoder (
  input  logic [`XLEN-1:0]    instId,
  output logic [`RegIdxW-1:0] rs1,
  output logic [`RegIdxW-1:0] rs2,
  output logic [`RegIdxW-1:0] rd,
  output logic [`XLEN-1:0]    imm,
  output rvIsaPkg::aluOpT     aluOp,
  output rvIsaPkg::memWidthT  memWidth,
  output logic                regWe,
  output logic                memWe,
  output logic                memRe,
  output logic                isUnsigned,
  output logic                useImm,
  output logic                usePc,
  output logic                isJump,
  output logic                isBranch,
  output logic                isEbreak,
  output logic                illegal
);

  rvIsaPkg::opcodeT opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] immI;
  logic [`XLEN-1:0] immS;
  logic [`XLEN-1:0] immB;
  logic [`XLEN-1:0] immU;
  logic [`XLEN-1:0] immJ;

  // shared by register-immediate and register-register forms
  function automatic rvIsaPkg::aluOpT aluFromF3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rvIsaPkg::aluSub : rvIsaPkg::aluAdd;
      3'b001:  return rvIsaPkg::aluSll;
      3'b010:  return rvIsaPkg::aluSlt;
      3'b011:  return rvIsaPkg::aluSltu;
      3'b100:  return rvIsaPkg::aluXor;
      3'b101:  return alt ? rvIsaPkg::aluSra : rvIsaPkg::aluSrl;
      3'b110:  return rvIsaPkg::aluOr;
      default: return rvIsaPkg::aluAnd;
    endcase
  endfunction

  assign opcode = rvIsaPkg::opcodeT'(instId[6:0]);
  assign rd     = instId[11:7];
  assign funct3 = instId[14:12];
  assign rs1    = instId[19:15];
  assign rs2    = instId[24:20];
  assign funct7 = instId[31:25];

  assign immI = {{20{instId[31]}}, instId[31:20]};
  assign immS = {{20{instId[31]}}, instId[31:25], instId[11:7]};
  assign immB = {{19{instId[31]}}, instId[31], instId[7], instId[30:25], instId[11:8], 1'b0};
  assign immU = {instId[31:12], 12'b0};
  assign immJ = {{11{instId[31]}}, instId[31], instId[19:12], instId[20], instId[30:21], 1'b0};

  always_comb begin
    imm        = '0;
    aluOp      = rvIsaPkg::aluAdd;
    memWidth   = rvIsaPkg::memWord;
    regWe      = 1'b0;
    memWe      = 1'b0;
    memRe      = 1'b0;
    isUnsigned = 1'b0;
    useImm     = 1'b0;
    usePc      = 1'b0;
    isJump     = 1'b0;
    isBranch   = 1'b0;
    isEbreak   = 1'b0;
    illegal    = 1'b0;
    case (opcode)
      rvIsaPkg::opLui: begin
        regWe  = 1'b1;
        useImm = 1'b1;
        imm    = immU;
        aluOp  = rvIsaPkg::aluPassB;
      end
      rvIsaPkg::opAuipc: begin
        regWe  = 1'b1;
        useImm = 1'b1;
        usePc  = 1'b1;
        imm    = immU;
      end
      rvIsaPkg::opJal: begin
        regWe  = 1'b1;
        useImm = 1'b1;
        usePc  = 1'b1;
        isJump = 1'b1;
        imm    = immJ;
      end
      rvIsaPkg::opJalr: begin
        regWe   = 1'b1;
        useImm  = 1'b1;
        isJump  = 1'b1;
        imm     = immI;
        illegal = (funct3 != 3'b000);
      end
      rvIsaPkg::opBranch: begin
        // compare rs1 against rs2, target adder uses immB
        isBranch = 1'b1;
        imm      = immB;
        case (funct3)
          3'b000:  aluOp = rvIsaPkg::aluEq;
          3'b001:  aluOp = rvIsaPkg::aluNe;
          3'b100:  aluOp = rvIsaPkg::aluSlt;
          3'b101:  aluOp = rvIsaPkg::aluGe;
          3'b110:  aluOp = rvIsaPkg::aluSltu;
          3'b111:  aluOp = rvIsaPkg::aluGeu;
          default: illegal = 1'b1;
        endcase
      end
      rvIsaPkg::opLoad: begin
        regWe      = 1'b1;
        memRe      = 1'b1;
        useImm     = 1'b1;
        imm        = immI;
        isUnsigned = funct3[2];
        memWidth   = rvIsaPkg::memWidthT'(funct3[1:0]);
        illegal    = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      rvIsaPkg::opStore: begin
        memWe    = 1'b1;
        useImm   = 1'b1;
        imm      = immS;
        memWidth = rvIsaPkg::memWidthT'(funct3[1:0]);
        illegal  = funct3[2] || (funct3[1:0] == 2'b11);
      end
      rvIsaPkg::opImm: begin
        regWe  = 1'b1;
        useImm = 1'b1;
        imm    = immI;
        aluOp  = aluFromF3(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001) illegal = (funct7 != 7'b0000000);
        if (funct3 == 3'b101) illegal = ({funct7[6], funct7[4:0]} != 6'b0);
      end
      rvIsaPkg::opReg: begin
        regWe = 1'b1;
        aluOp = aluFromF3(funct3, funct7[5]);
        if (funct7 == 7'b0100000) illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        else illegal = (funct7 != 7'b0000000);
      end
      rvIsaPkg::opSystem: begin
        // only ebreak is implemented
        if (instId == 32'h0010_0073) isEbreak = 1'b1;
        else illegal = 1'b1;
      end
      default: illegal = 1'b1;
    endcase

    // an illegal encoding must not write or redirect
    if (illegal) begin
      regWe    = 1'b0;
      memWe    = 1'b0;
      memRe    = 1'b0;
      isJump   = 1'b0;
      isBranch = 1'b0;
    end
  end

endmodule

/* design/runControl.sv */
`timescale 1ns/1ns

module runControl (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic haltReq,
  input  logic illegalReq,
  output logic runEn,
  output logic restart,
  output logic done,
  output logic trap
);

  cpuCtrlPkg::runStateT state;
  cpuCtrlPkg::runStateT stateNext;

  always_comb begin
    stateNext = state;
    case (state)
      cpuCtrlPkg::stIdle: begin
        if (start) stateNext = cpuCtrlPkg::stRun;
      end
      cpuCtrlPkg::stRun: begin
        if (haltReq) stateNext = cpuCtrlPkg::stHalted;
        else if (illegalReq) stateNext = cpuCtrlPkg::stTrapped;
      end
      // a new start drops back to idle with the pc reloaded
      default: begin
        if (start) stateNext = cpuCtrlPkg::stIdle;
      end
    endcase
  end

  assign runEn   = (state == cpuCtrlPkg::stRun);
  assign restart = start && (state == cpuCtrlPkg::stHalted || state == cpuCtrlPkg::stTrapped);

  // status lags state entry by a cycle and drops with the leaving edge
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cpuCtrlPkg::stIdle;
      done  <= 1'b0;
      trap  <= 1'b0;
    end else begin
      state <= stateNext;
      done  <= (state == cpuCtrlPkg::stHalted) && (stateNext == cpuCtrlPkg::stHalted);
      trap  <= (state == cpuCtrlPkg::stTrapped) && (stateNext == cpuCtrlPkg::stTrapped);
    end
  end

endmodule

/* design/fetchStage.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module fetchStage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  runEn,
  input  logic                  restart,
  input  cpuCtrlPkg::pcSrcT     pcSrc,
  input  logic [`XLEN-1:0]      targetPc,
  input  logic                  flush,
  input  logic                  imemWe,
  input  logic [`ImemAddrW-1:0] imemAddr,
  input  logic [`XLEN-1:0]      imemData,
  output logic [`XLEN-1:0]      pc,
  output logic [`XLEN-1:0]      pcId,
  output logic [`XLEN-1:0]      instId
);

  logic [`XLEN-1:0] imem [`ImemWords];
  logic [`XLEN-1:0] instFetch;

  // loader writes only while the core is not running
  always_ff @(posedge clk) begin
    if (imemWe && !runEn) begin
      imem[imemAddr] <= imemData;
    end
  end

  assign instFetch = imem[pc[`ImemAddrW+1:2]];

  always_ff @(posedge clk) begin
    if (rst || restart) begin
      pc <= `PcReset;
    end else if (runEn) begin
      if (pcSrc == cpuCtrlPkg::pcSeq) begin
        pc <= pc + `XLEN'(4);
      end else begin
        pc <= targetPc;
      end
    end
  end

  // decode register takes a bubble on flush or when stopped
  always_ff @(posedge clk) begin
    if (rst || flush || !runEn) begin
      instId <= `Nop;
      pcId   <= '0;
    end else begin
      instId <= instFetch;
      pcId   <= pc;
    end
  end

endmodule

/* design/cpuCtrlPkg.sv */
package cpuCtrlPkg;

  typedef enum logic [1:0] {
    stIdle,
    stRun,
    stHalted,
    stTrapped
  } runStateT;

  // where the next fetch pc comes from
  typedef enum logic [1:0] {
    pcSeq,
    pcBranch,
    pcJump
  } pcSrcT;

endpackage

/* design/rvIsaPkg.sv */
package rvIsaPkg;

  // major opcodes in bits 6:0 of the instruction
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,
    opReg    = 7'b0110011,
    opSystem = 7'b1110011
  } opcodeT;

  // compare ops return 0 or 1
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluEq,
    aluNe,
    aluGe,
    aluGeu,
    aluPassB
  } aluOpT;

  typedef enum logic [1:0] {
    memByte,
    memHalf,
    memWord
  } memWidthT;

endpackage

/* design/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data and address width
`define XLEN 32

// architectural registers
`define RegCount 32
`define RegIdxW $clog2(`RegCount)

// memory sizes
`define ImemWords 256
`define ImemAddrW $clog2(`ImemWords)
`define DmemBytes 1024
`define DmemAddrW $clog2(`DmemBytes)

`define PcReset 32'h0000_0000

// addi x0, x0, 0
`define Nop 32'h0000_0013

`endif
